// ==== afifo_pkg.sv ====
package afifo_pkg;

  ////////////////////////////////
  // sizing constants
  ////////////////////////////////

  localparam int SYNC_STAGES_C    = 2;  // flops per gray pointer sync
  localparam int REG_ADDR_WIDTH_C = 2;  // prefetch fifo, 4 entries
  localparam int PREFETCH_LIMIT_C = 2;  // issue core read at or below this

  // pointers are zero extended into one word for the conversions
  localparam int PTR_WORD_WIDTH_C = 32;
  typedef logic [PTR_WORD_WIDTH_C-1:0] ptr_word_t;

  ////////////////////////////////
  // gray code helpers
  ////////////////////////////////

  function automatic ptr_word_t bin_to_gray(ptr_word_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic ptr_word_t gray_to_bin(ptr_word_t gray);
    ptr_word_t bin;
    bin = gray;  // msb passes straight through
    for (int i = PTR_WORD_WIDTH_C - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];  // running xor from the top
    end
    return bin;
  endfunction

endpackage

// ==== afifo_mem.sv ====
module afifo_mem #(
  parameter int DATA_WIDTH_P = 16,
  parameter int ADDR_WIDTH_P = 3
) (
  // write port
  input  wire                      clk_wp,
  input  wire                      mem_wr_en,
  input  wire   [ADDR_WIDTH_P-1:0] waddr,
  input  wire   [DATA_WIDTH_P-1:0] wdata,

  // read port
  input  wire                      clk_rp,
  input  wire   [ADDR_WIDTH_P-1:0] raddr,
  output logic  [DATA_WIDTH_P-1:0] rdata
);

  localparam int DEPTH_C = 2 ** ADDR_WIDTH_P;

  logic [DATA_WIDTH_P-1:0] mem [DEPTH_C];  // storage, no reset

  ////////////////////////////////
  // write side
  ////////////////////////////////

  always_ff @(posedge clk_wp) begin
    if (mem_wr_en) begin
      mem[waddr] <= wdata;  // write pointer owns this slot
    end
  end

  ////////////////////////////////
  // read side
  ////////////////////////////////

  // registered read, word shows one clk_rp cycle after raddr
  // slot at raddr was written several clk_rp cycles earlier, the
  // pointer sync guarantees that before the core reports not empty
  always_ff @(posedge clk_rp) begin
    rdata <= mem[raddr];
  end

endmodule

// ==== afifo_wptr.sv ====
module afifo_wptr #(
  parameter int ADDR_WIDTH_P = 3
) (
  input  wire                      clk_wp,
  input  wire                      rst_wp_n,
  input  wire                      wp_write_en,

  input  wire   [ADDR_WIDTH_P:0]   rgray,      // from read domain
  output logic  [ADDR_WIDTH_P:0]   wgray,      // to read domain

  output logic  [ADDR_WIDTH_P-1:0] waddr,
  output logic                     mem_wr_en,

  output logic                     wp_fifo_full,
  output logic  [ADDR_WIDTH_P:0]   sr_wp_fill_level,
  output logic  [ADDR_WIDTH_P:0]   sr_wp_max_fill_level,
  output logic                     sr_wp_fifo_active
);

  localparam int PTR_W_C = ADDR_WIDTH_P + 1;
  // top two gray bits flipped means a full lap apart
  localparam logic [ADDR_WIDTH_P:0] FULL_MASK_C = PTR_W_C'(3) << (ADDR_WIDTH_P - 1);

  logic [ADDR_WIDTH_P:0] wbin;
  logic [ADDR_WIDTH_P:0] wbin_next;
  logic [ADDR_WIDTH_P:0] wgray_next;
  logic [ADDR_WIDTH_P:0] rgray_sync [afifo_pkg::SYNC_STAGES_C];
  logic [ADDR_WIDTH_P:0] rbin_sync;

  ////////////////////////////////
  // pointer advance
  ////////////////////////////////

  assign mem_wr_en  = wp_write_en && !wp_fifo_full;  // full drops the write
  assign waddr      = wbin[ADDR_WIDTH_P-1:0];
  assign wbin_next  = wbin + PTR_W_C'(mem_wr_en);
  assign wgray_next = PTR_W_C'(afifo_pkg::bin_to_gray(afifo_pkg::ptr_word_t'(wbin_next)));

  always_ff @(posedge clk_wp or negedge rst_wp_n) begin
    if (!rst_wp_n) begin
      wbin         <= '0;
      wgray        <= '0;
      wp_fifo_full <= 1'b0;
    end else begin
      wbin         <= wbin_next;
      wgray        <= wgray_next;
      wp_fifo_full <= (wgray_next == (rgray_sync[afifo_pkg::SYNC_STAGES_C-1] ^ FULL_MASK_C));
    end
  end

  // read pointer into write domain
  always_ff @(posedge clk_wp or negedge rst_wp_n) begin
    if (!rst_wp_n) begin
      rgray_sync <= '{default: '0};
    end else begin
      rgray_sync[0] <= rgray;  // first stage, may go metastable
      for (int i = 1; i < afifo_pkg::SYNC_STAGES_C; i++) begin
        rgray_sync[i] <= rgray_sync[i-1];
      end
    end
  end

  ////////////////////////////////
  // status
  ////////////////////////////////

  assign rbin_sync = PTR_W_C'(afifo_pkg::gray_to_bin(
                       afifo_pkg::ptr_word_t'(rgray_sync[afifo_pkg::SYNC_STAGES_C-1])));

  assign sr_wp_fill_level  = wbin - rbin_sync;  // words still in the core
  assign sr_wp_fifo_active = (sr_wp_fill_level != '0);

  always_ff @(posedge clk_wp or negedge rst_wp_n) begin
    if (!rst_wp_n) begin
      sr_wp_max_fill_level <= '0;
    end else if (sr_wp_fill_level > sr_wp_max_fill_level) begin
      sr_wp_max_fill_level <= sr_wp_fill_level;  // new high mark
    end
  end

endmodule

// ==== afifo_rptr.sv ====
module afifo_rptr #(
  parameter int ADDR_WIDTH_P = 3
) (
  input  wire                      clk_rp,
  input  wire                      rst_rp_n,
  input  wire                      core_rd_en,

  input  wire   [ADDR_WIDTH_P:0]   wgray,      // from write domain
  output logic  [ADDR_WIDTH_P:0]   rgray,      // to write domain

  output logic  [ADDR_WIDTH_P-1:0] raddr,
  output logic                     core_empty,
  output logic  [ADDR_WIDTH_P:0]   core_fill_level
);

  localparam int PTR_W_C = ADDR_WIDTH_P + 1;

  logic [ADDR_WIDTH_P:0] rbin;
  logic [ADDR_WIDTH_P:0] rbin_next;
  logic [ADDR_WIDTH_P:0] rgray_next;
  logic [ADDR_WIDTH_P:0] wgray_sync [afifo_pkg::SYNC_STAGES_C];
  logic [ADDR_WIDTH_P:0] wbin_sync;

  ////////////////////////////////
  // pointer advance
  ////////////////////////////////

  assign raddr      = rbin[ADDR_WIDTH_P-1:0];  // memory samples this on the read edge
  assign rbin_next  = rbin + PTR_W_C'(core_rd_en);
  assign rgray_next = PTR_W_C'(afifo_pkg::bin_to_gray(afifo_pkg::ptr_word_t'(rbin_next)));

  always_ff @(posedge clk_rp or negedge rst_rp_n) begin
    if (!rst_rp_n) begin
      rbin       <= '0;
      rgray      <= '0;
      core_empty <= 1'b1;  // nothing written yet
    end else begin
      rbin       <= rbin_next;
      rgray      <= rgray_next;
      core_empty <= (rgray_next == wgray_sync[afifo_pkg::SYNC_STAGES_C-1]);
    end
  end

  // write pointer into read domain
  always_ff @(posedge clk_rp or negedge rst_rp_n) begin
    if (!rst_rp_n) begin
      wgray_sync <= '{default: '0};
    end else begin
      wgray_sync[0] <= wgray;
      for (int i = 1; i < afifo_pkg::SYNC_STAGES_C; i++) begin
        wgray_sync[i] <= wgray_sync[i-1];
      end
    end
  end

  ////////////////////////////////
  // status
  ////////////////////////////////

  assign wbin_sync = PTR_W_C'(afifo_pkg::gray_to_bin(
                       afifo_pkg::ptr_word_t'(wgray_sync[afifo_pkg::SYNC_STAGES_C-1])));

  assign core_fill_level = wbin_sync - rbin;  // lags writes by the sync depth

endmodule

// ==== fifo_register.sv ====
module fifo_register #(
  parameter int DATA_WIDTH_P = 16,
  parameter int ADDR_WIDTH_P = 2
) (
  input  wire                      clk_rp,
  input  wire                      rst_rp_n,

  // ingress, caller keeps it from overfilling
  input  wire                      ing_enable,
  input  wire   [DATA_WIDTH_P-1:0] ing_data,

  // egress, head always on egr_data
  input  wire                      egr_enable,
  output logic  [DATA_WIDTH_P-1:0] egr_data,
  output logic                     egr_empty,

  output logic  [ADDR_WIDTH_P:0]   sr_fill_level
);

  localparam int DEPTH_C = 2 ** ADDR_WIDTH_P;

  logic [DATA_WIDTH_P-1:0] regs [DEPTH_C];
  logic [ADDR_WIDTH_P-1:0] wr_ptr;
  logic [ADDR_WIDTH_P-1:0] rd_ptr;
  logic                    egr_accept;

  assign egr_empty  = (sr_fill_level == '0);
  assign egr_accept = egr_enable && !egr_empty;  // pop on empty is dropped
  assign egr_data   = regs[rd_ptr];              // show-ahead head word

  ////////////////////////////////
  // storage
  ////////////////////////////////

  always_ff @(posedge clk_rp) begin
    if (ing_enable) begin
      regs[wr_ptr] <= ing_data;
    end
  end

  ////////////////////////////////
  // pointers and level
  ////////////////////////////////

  always_ff @(posedge clk_rp or negedge rst_rp_n) begin
    if (!rst_rp_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      sr_fill_level <= '0;
    end else begin
      if (ing_enable) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      end
      if (egr_accept) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({ing_enable, egr_accept})
        2'b10:   sr_fill_level <= sr_fill_level + 1'b1;
        2'b01:   sr_fill_level <= sr_fill_level - 1'b1;
        default: sr_fill_level <= sr_fill_level;  // both or none
      endcase
    end
  end

endmodule

// ==== afifo_rd_ctrl.sv ====
module afifo_rd_ctrl #(
  parameter int ADDR_WIDTH_P = 3
) (
  input  wire                                     clk_rp,
  input  wire                                     rst_rp_n,

  input  wire                                     core_empty,
  input  wire   [afifo_pkg::REG_ADDR_WIDTH_C:0]   pf_fill_level,
  input  wire   [ADDR_WIDTH_P:0]                  core_fill_level,
  input  wire                                     rp_fifo_empty,

  output logic                                    core_rd_en,
  output logic                                    pf_wr_en,
  output logic  [ADDR_WIDTH_P:0]                  sr_rp_fill_level,
  output logic                                    sr_rp_fifo_active
);

  localparam int LVL_W_C = ADDR_WIDTH_P + 1;
  localparam int PF_W_C  = afifo_pkg::REG_ADDR_WIDTH_C + 1;

  logic [afifo_pkg::REG_ADDR_WIDTH_C:0] pf_level_pending;

  ////////////////////////////////
  // prefetch decision
  ////////////////////////////////

  // count the word still coming out of the memory register,
  // else two back to back reads overshoot the limit
  assign pf_level_pending = pf_fill_level + PF_W_C'(pf_wr_en);

  assign core_rd_en = !core_empty && (pf_level_pending <= afifo_pkg::PREFETCH_LIMIT_C);

  // memory data lands one cycle after the core read
  always_ff @(posedge clk_rp or negedge rst_rp_n) begin
    if (!rst_rp_n) begin
      pf_wr_en <= 1'b0;
    end else begin
      pf_wr_en <= core_rd_en;
    end
  end

  ////////////////////////////////
  // read side status
  ////////////////////////////////

  always_comb begin
    if (rp_fifo_empty) begin
      sr_rp_fill_level = '0;  // nothing readable yet
    end else begin
      sr_rp_fill_level = core_fill_level + LVL_W_C'(pf_fill_level);
    end
  end

  assign sr_rp_fifo_active = (sr_rp_fill_level != '0);

endmodule

// ==== afifo.sv ====
module afifo #(
  parameter int DATA_WIDTH_P = 16,
  parameter int ADDR_WIDTH_P = 3
) (
  input  wire                      clk_wp,
  input  wire                      rst_wp_n,
  input  wire                      clk_rp,
  input  wire                      rst_rp_n,

  // write side
  input  wire                      wp_write_en,
  input  wire   [DATA_WIDTH_P-1:0] wp_data_in,
  output logic                     wp_fifo_full,

  // read side
  input  wire                      rp_read_en,
  output logic  [DATA_WIDTH_P-1:0] rp_data_out,
  output logic                     rp_fifo_empty,

  // status, write domain
  output logic                     sr_wp_fifo_active,
  output logic  [ADDR_WIDTH_P:0]   sr_wp_fill_level,
  output logic  [ADDR_WIDTH_P:0]   sr_wp_max_fill_level,

  // status, read domain
  output logic                     sr_rp_fifo_active,
  output logic  [ADDR_WIDTH_P:0]   sr_rp_fill_level
);

  // crossing pointers
  logic [ADDR_WIDTH_P:0]   wgray;
  logic [ADDR_WIDTH_P:0]   rgray;

  // core memory
  logic                    mem_wr_en;
  logic [ADDR_WIDTH_P-1:0] waddr;
  logic [ADDR_WIDTH_P-1:0] raddr;
  logic [DATA_WIDTH_P-1:0] rdata;

  // read control
  logic                    core_rd_en;
  logic                    core_empty;
  logic [ADDR_WIDTH_P:0]   core_fill_level;
  logic                    pf_wr_en;
  logic [afifo_pkg::REG_ADDR_WIDTH_C:0] pf_fill_level;

  ////////////////////////////////
  // write domain
  ////////////////////////////////

  afifo_wptr #(
    .ADDR_WIDTH_P         (ADDR_WIDTH_P)
  ) i_afifo_wptr (
    .clk_wp               (clk_wp),
    .rst_wp_n             (rst_wp_n),
    .wp_write_en          (wp_write_en),
    .rgray                (rgray),
    .wgray                (wgray),
    .waddr                (waddr),
    .mem_wr_en            (mem_wr_en),
    .wp_fifo_full         (wp_fifo_full),
    .sr_wp_fill_level     (sr_wp_fill_level),
    .sr_wp_max_fill_level (sr_wp_max_fill_level),
    .sr_wp_fifo_active    (sr_wp_fifo_active)
  );

  afifo_mem #(
    .DATA_WIDTH_P (DATA_WIDTH_P),
    .ADDR_WIDTH_P (ADDR_WIDTH_P)
  ) i_afifo_mem (
    .clk_wp    (clk_wp),
    .mem_wr_en (mem_wr_en),
    .waddr     (waddr),
    .wdata     (wp_data_in),
    .clk_rp    (clk_rp),
    .raddr     (raddr),
    .rdata     (rdata)  // one cycle behind core_rd_en
  );

  ////////////////////////////////
  // read domain
  ////////////////////////////////

  afifo_rptr #(
    .ADDR_WIDTH_P (ADDR_WIDTH_P)
  ) i_afifo_rptr (
    .clk_rp          (clk_rp),
    .rst_rp_n        (rst_rp_n),
    .core_rd_en      (core_rd_en),
    .wgray           (wgray),
    .rgray           (rgray),
    .raddr           (raddr),
    .core_empty      (core_empty),
    .core_fill_level (core_fill_level)
  );

  fifo_register #(
    .DATA_WIDTH_P (DATA_WIDTH_P),
    .ADDR_WIDTH_P (afifo_pkg::REG_ADDR_WIDTH_C)
  ) i_fifo_register (
    .clk_rp        (clk_rp),
    .rst_rp_n      (rst_rp_n),
    .ing_enable    (pf_wr_en),
    .ing_data      (rdata),
    .egr_enable    (rp_read_en),  // qualified by empty inside
    .egr_data      (rp_data_out),
    .egr_empty     (rp_fifo_empty),
    .sr_fill_level (pf_fill_level)
  );

  afifo_rd_ctrl #(
    .ADDR_WIDTH_P (ADDR_WIDTH_P)
  ) i_afifo_rd_ctrl (
    .clk_rp            (clk_rp),
    .rst_rp_n          (rst_rp_n),
    .core_empty        (core_empty),
    .pf_fill_level     (pf_fill_level),
    .core_fill_level   (core_fill_level),
    .rp_fifo_empty     (rp_fifo_empty),
    .core_rd_en        (core_rd_en),
    .pf_wr_en          (pf_wr_en),
    .sr_rp_fill_level  (sr_rp_fill_level),
    .sr_rp_fifo_active (sr_rp_fifo_active)
  );

endmodule

// ==== afifo_assert.sv ====
module afifo_assert #(
  parameter int ADDR_WIDTH_P = 3
) (
  input  wire                                   clk_rp,
  input  wire                                   rst_rp_n,
  input  wire                                   core_empty,
  input  wire                                   core_rd_en,
  input  wire                                   pf_wr_en,
  input  wire   [afifo_pkg::REG_ADDR_WIDTH_C:0] pf_fill_level,
  input  wire   [ADDR_WIDTH_P:0]                core_fill_level
);

  localparam int PF_DEPTH_C = 2 ** afifo_pkg::REG_ADDR_WIDTH_C;

  int fail_count = 0;  // failed assertions so far

  //////////////////////////////
  // prefetch occupancy
  //////////////////////////////

  prefetch_depth: assert property (@(posedge clk_rp) disable iff (!rst_rp_n)
    pf_fill_level <= PF_DEPTH_C)
    else begin
      fail_count++;
      $error("prefetch level %0d above depth %0d", pf_fill_level, PF_DEPTH_C);
    end

  // stored plus in flight stays one above the issue limit
  prefetch_limit: assert property (@(posedge clk_rp) disable iff (!rst_rp_n)
    (pf_fill_level + pf_wr_en) <= afifo_pkg::PREFETCH_LIMIT_C + 1)
    else begin
      fail_count++;
      $error("prefetch overshoot, level %0d with ingress %0b", pf_fill_level, pf_wr_en);
    end

  //////////////////////////////
  // core read and ingress
  //////////////////////////////

  // word read from the core lands in the prefetch two cycles on
  ingress_follows_read: assert property (@(posedge clk_rp) disable iff (!rst_rp_n)
    core_rd_en |=> pf_wr_en ##1 (pf_fill_level != '0))
    else begin
      fail_count++;
      $error("core read word did not reach the prefetch fifo");
    end

  // the core level must agree that a word is there
  no_read_when_empty: assert property (@(posedge clk_rp) disable iff (!rst_rp_n)
    core_rd_en |-> (!core_empty && (core_fill_level != '0)))
    else begin
      fail_count++;
      $error("core read issued while the core holds no word");
    end

endmodule

// ==== tb_afifo.sv ====
module tb_afifo;

  localparam int DATA_WIDTH_C = 16;
  localparam int ADDR_WIDTH_C = 3;
  localparam int CORE_DEPTH_C = 2 ** ADDR_WIDTH_C;
  localparam int PF_HOLD_C    = afifo_pkg::PREFETCH_LIMIT_C + 1;  // words parked in prefetch
  localparam int ORDER_OPS_C  = 400;
  localparam int FILL_OPS_C   = 40;
  localparam int DRAIN_OPS_C  = 64;
  localparam int TIMEOUT_C    = 20 * (ORDER_OPS_C + FILL_OPS_C + 2 * DRAIN_OPS_C);

  logic                      clk_wp = 1'b0;
  logic                      clk_rp = 1'b0;
  logic                      rst_wp_n;
  logic                      rst_rp_n;
  logic                      wp_write_en;
  logic [DATA_WIDTH_C-1:0]   wp_data_in;
  logic                      wp_fifo_full;
  logic                      rp_read_en;
  logic [DATA_WIDTH_C-1:0]   rp_data_out;
  logic                      rp_fifo_empty;
  logic                      sr_wp_fifo_active;
  logic [ADDR_WIDTH_C:0]     sr_wp_fill_level;
  logic [ADDR_WIDTH_C:0]     sr_wp_max_fill_level;
  logic                      sr_rp_fifo_active;
  logic [ADDR_WIDTH_C:0]     sr_rp_fill_level;

  logic [DATA_WIDTH_C-1:0]   model_q [$];  // accepted words, oldest first
  int                        test_errors;
  int                        error_total;
  int                        tests_run;
  int                        tests_failed;
  int                        accepted_writes;
  int                        max_wp_level;      // highest settled write level
  int                        cycle_count = 0;
  bit                        writer_done;

  always #2 clk_rp = ~clk_rp;  // period 4
  always #3 clk_wp = ~clk_wp;  // period 6

  afifo #(
    .DATA_WIDTH_P (DATA_WIDTH_C),
    .ADDR_WIDTH_P (ADDR_WIDTH_C)
  ) i_afifo (
    .clk_wp               (clk_wp),
    .rst_wp_n             (rst_wp_n),
    .clk_rp               (clk_rp),
    .rst_rp_n             (rst_rp_n),
    .wp_write_en          (wp_write_en),
    .wp_data_in           (wp_data_in),
    .wp_fifo_full         (wp_fifo_full),
    .rp_read_en           (rp_read_en),
    .rp_data_out          (rp_data_out),
    .rp_fifo_empty        (rp_fifo_empty),
    .sr_wp_fifo_active    (sr_wp_fifo_active),
    .sr_wp_fill_level     (sr_wp_fill_level),
    .sr_wp_max_fill_level (sr_wp_max_fill_level),
    .sr_rp_fifo_active    (sr_rp_fifo_active),
    .sr_rp_fill_level     (sr_rp_fill_level)
  );

  bind afifo_rd_ctrl afifo_assert #(
    .ADDR_WIDTH_P (ADDR_WIDTH_P)
  ) i_afifo_assert (
    .clk_rp          (clk_rp),
    .rst_rp_n        (rst_rp_n),
    .core_empty      (core_empty),
    .core_rd_en      (core_rd_en),
    .pf_wr_en        (pf_wr_en),
    .pf_fill_level   (pf_fill_level),
    .core_fill_level (core_fill_level)
  );

  always @(posedge clk_rp) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_C) begin
      $display("timeout, tests still running after %0d clk_rp cycles", TIMEOUT_C);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////
  // bookkeeping
  //////////////////////////////

  task automatic start_test();
    test_errors = 0;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    error_total += test_errors;
    if (test_errors == 0) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, test_errors);
    end
  endtask

  task automatic report_mismatch(input string name, input int expected, input int actual);
    test_errors++;
    $display("** Error %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
  endtask

  //////////////////////////////
  // drivers
  //////////////////////////////

  // rate in quarters, 4 means every cycle
  task automatic write_cycles(input int n, input int rate);
    bit en;
    repeat (n) begin
      @(posedge clk_wp);
      #1;
      en          = ($urandom % 4) < rate;
      wp_write_en = en;
      wp_data_in  = DATA_WIDTH_C'($urandom);
      if (en && !wp_fifo_full) begin  // full is steady until the next edge
        model_q.push_back(wp_data_in);
        accepted_writes++;
      end
    end
    @(posedge clk_wp);
    #1;
    wp_write_en = 1'b0;
  endtask

  task automatic read_cycle(input string name, input int rate);
    @(posedge clk_rp);
    #1;
    rp_read_en = ($urandom % 4) < rate;
    if (rp_read_en && !rp_fifo_empty) begin  // pop lands on the next edge
      if (model_q.size() == 0) begin
        test_errors++;
        $display("%s: read accepted while no word was expected", name);
      end else begin
        if (rp_data_out !== model_q[0]) begin
          report_mismatch(name, model_q[0], rp_data_out);
        end
        void'(model_q.pop_front());
      end
    end
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic run_ordering();
    int read_rate;
    start_test();
    writer_done = 1'b0;
    fork
      begin
        repeat (ORDER_OPS_C / 50) write_cycles(50, $urandom_range(1, 4));
        writer_done = 1'b1;
      end
      begin
        while (!writer_done) begin
          read_rate = $urandom_range(0, 4);  // zero lets the fifo fill up
          repeat (40) read_cycle("ordering", read_rate);
        end
        read_cycle("ordering", 0);
      end
    join
    end_test("ordering");
  endtask

  task automatic run_drain(input string name);
    int guard;
    start_test();
    guard = 0;
    while (model_q.size() != 0 && guard < DRAIN_OPS_C) begin
      read_cycle(name, 2);
      guard++;
    end
    if (model_q.size() != 0) begin
      test_errors++;
      $display("%s: %0d accepted words never came out", name, model_q.size());
    end
    // keep pulsing reads on an empty fifo
    repeat (10) begin
      read_cycle(name, 4);
      if (!rp_fifo_empty) begin
        test_errors++;
        $display("%s: rp_fifo_empty low after the last word was read", name);
      end
    end
    read_cycle(name, 0);
    end_test(name);
  endtask

  task automatic check_levels(input string name);
    int count;
    int wp_exp;
    start_test();
    repeat (10) @(posedge clk_rp);
    #1;
    count  = model_q.size();
    wp_exp = count - ((count < PF_HOLD_C) ? count : PF_HOLD_C);  // prefetch takes the oldest
    if (wp_exp > max_wp_level) begin
      max_wp_level = wp_exp;
    end
    if (sr_rp_fill_level !== count) begin
      report_mismatch({name, " rp level"}, count, sr_rp_fill_level);
    end
    if (sr_wp_fill_level !== wp_exp) begin
      report_mismatch({name, " wp level"}, wp_exp, sr_wp_fill_level);
    end
    if (sr_rp_fifo_active !== (count != 0)) begin
      report_mismatch({name, " rp active"}, count != 0, sr_rp_fifo_active);
    end
    if (sr_wp_fifo_active !== (wp_exp != 0)) begin
      report_mismatch({name, " wp active"}, wp_exp != 0, sr_wp_fifo_active);
    end
    end_test(name);
  endtask

  task automatic run_capacity();
    start_test();
    accepted_writes = 0;
    write_cycles(FILL_OPS_C, 4);  // no reads, write every cycle
    repeat (10) @(posedge clk_rp);
    #1;
    if (accepted_writes != CORE_DEPTH_C + PF_HOLD_C) begin
      report_mismatch("capacity", CORE_DEPTH_C + PF_HOLD_C, accepted_writes);
    end
    if (!wp_fifo_full) begin
      test_errors++;
      $display("capacity: wp_fifo_full low with the fifo at capacity");
    end
    end_test("capacity");
  endtask

  task automatic check_watermark();
    start_test();
    if (sr_wp_max_fill_level !== max_wp_level) begin
      report_mismatch("watermark", max_wp_level, sr_wp_max_fill_level);
    end
    end_test("watermark");
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    int assert_fails;
    void'($urandom(32'h4c34));
    rst_wp_n        = 1'b0;
    rst_rp_n        = 1'b0;
    wp_write_en     = 1'b0;
    wp_data_in      = '0;
    rp_read_en      = 1'b0;
    error_total     = 0;
    tests_run       = 0;
    tests_failed    = 0;
    accepted_writes = 0;
    max_wp_level    = 0;
    repeat (8) @(posedge clk_rp);
    #1;
    rst_rp_n = 1'b1;
    @(posedge clk_wp);  // release each side away from its own edge
    #1;
    rst_wp_n = 1'b1;

    run_ordering();
    run_drain("drain");
    check_levels("levels_empty");
    run_capacity();
    check_levels("levels_full");
    run_drain("drain_full");
    check_levels("levels_final");
    check_watermark();  // level is back at zero, mark must hold the peak

    assert_fails = i_afifo.i_afifo_rd_ctrl.i_afifo_assert.fail_count;
    $display("tests %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
             tests_run, tests_run - tests_failed, tests_failed, error_total, assert_fails);
    if (tests_failed == 0 && assert_fails == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
afifo_pkg.sv
afifo_mem.sv
afifo_wptr.sv
afifo_rptr.sv
fifo_register.sv
afifo_rd_ctrl.sv
afifo.sv
afifo_assert.sv
tb_afifo.sv

// ==== Bender.yml ====
package:
  name: afifo

sources:
  - afifo_pkg.sv
  - afifo_mem.sv
  - afifo_wptr.sv
  - afifo_rptr.sv
  - fifo_register.sv
  - afifo_rd_ctrl.sv
  - afifo.sv
  - target: test
    files:
      - afifo_assert.sv
      - tb_afifo.sv
